//--- hw/fp_pkg.sv
`default_nettype none

package fp_pkg;

    // binary32 field layout
    localparam int exp_w    = 8;
    localparam int man_w    = 23;
    localparam int word_w   = 1 + exp_w + man_w;
    localparam int exp_bias = 127;
    localparam int exp_max  = (1 << exp_w) - 1;         // all-ones exponent, inf

    // working mantissa: carry, hidden, fraction, guard, round, sticky
    localparam int grs_w    = 3;
    localparam int ext_w    = 1 + (man_w + 1) + grs_w;  // 28

    typedef logic [word_w-1:0]       fp_word_t;
    typedef logic [exp_w-1:0]        exp_t;
    typedef logic signed [exp_w+1:0] exp_wide_t;        // room for +1 and borrow
    typedef logic [man_w:0]          sig_t;             // hidden bit + fraction
    typedef logic [ext_w-1:0]        work_man_t;

endpackage

`default_nettype wire

//--- hw/fp_stage_if.sv
`default_nettype none

// one operation in flight between two pipeline stages
// s1 hop (order -> align) uses every field
// s2 hop (align -> round) uses valid, sign, exp_big, man_big (the sum) and both_zero_neg
interface fp_stage_if
    import fp_pkg::*;
#(
    parameter int work_w = ext_w
);

    logic              valid;
    logic              sign;           // result sign
    logic              sub;            // effective subtraction
    exp_t              exp_big;        // exponent of larger operand, subnormal as 1
    logic [work_w-1:0] man_big;
    logic [work_w-1:0] man_small;
    exp_t              exp_diff;       // saturated alignment distance
    logic              both_zero_neg;  // -0 op -0, forces -0 on a zero result

    modport src (
        output valid, sign, sub, exp_big, man_big, man_small, exp_diff, both_zero_neg
    );

    modport dst (
        input valid, sign, sub, exp_big, man_big, man_small, exp_diff, both_zero_neg
    );

endinterface

`default_nettype wire

//--- hw/fp_operand_order.sv
`default_nettype none

module fp_operand_order
    import fp_pkg::*;
#(
    parameter int work_w = ext_w
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  logic     op_add,     // 1 add, 0 subtract
    input  fp_word_t operand_a,
    input  fp_word_t operand_b,
    fp_stage_if.src  s1
);

    logic      a_sign;
    logic      b_sign;
    exp_t      a_exp_raw;
    exp_t      b_exp_raw;
    exp_t      a_exp;
    exp_t      b_exp;
    sig_t      a_sig;
    sig_t      b_sig;
    logic      a_ge_b;
    exp_t      big_exp;
    exp_t      small_exp;
    exp_t      diff;
    exp_t      diff_sat;
    work_man_t big_man;
    work_man_t small_man;
    logic      zero_neg;

    assign a_sign    = operand_a[word_w-1];
    assign b_sign    = operand_b[word_w-1] ^ ~op_add;            // subtract flips b
    assign a_exp_raw = operand_a[man_w +: exp_w];
    assign b_exp_raw = operand_b[man_w +: exp_w];

    assign a_sig = {a_exp_raw != '0, operand_a[man_w-1:0]};     // hidden bit
    assign b_sig = {b_exp_raw != '0, operand_b[man_w-1:0]};
    assign a_exp = (a_exp_raw == '0) ? exp_t'(1) : a_exp_raw;   // subnormal runs at 1
    assign b_exp = (b_exp_raw == '0) ? exp_t'(1) : b_exp_raw;

    // exponent then fraction, so the raw magnitude bits compare directly
    assign a_ge_b = operand_a[word_w-2:0] >= operand_b[word_w-2:0];

    assign big_exp   = a_ge_b ? a_exp : b_exp;
    assign small_exp = a_ge_b ? b_exp : a_exp;
    assign big_man   = {1'b0, (a_ge_b ? a_sig : b_sig), {grs_w{1'b0}}};
    assign small_man = {1'b0, (a_ge_b ? b_sig : a_sig), {grs_w{1'b0}}};

    assign diff     = big_exp - small_exp;
    assign diff_sat = (diff > exp_t'(work_w - 1)) ? exp_t'(work_w - 1) : diff;  // keep shifter small

    assign zero_neg = a_sign & b_sign
                    & (operand_a[word_w-2:0] == '0) & (operand_b[word_w-2:0] == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1.valid <= 1'b0;
        end else begin
            s1.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1.sign          <= a_ge_b ? a_sign : b_sign;  // larger magnitude wins
        s1.sub           <= a_sign ^ b_sign;
        s1.exp_big       <= big_exp;
        s1.man_big       <= big_man;
        s1.man_small     <= small_man;
        s1.exp_diff      <= diff_sat;
        s1.both_zero_neg <= zero_neg;
    end

endmodule

`default_nettype wire

//--- hw/fp_align_add.sv
`default_nettype none

module fp_align_add
    import fp_pkg::*;
#(
    parameter int work_w = ext_w
) (
    input  logic    clk,
    input  logic    rst,
    fp_stage_if.dst s1,
    fp_stage_if.src s2
);

    logic [work_w-1:0] lost_mask;
    logic [work_w-1:0] shifted;
    logic [work_w-1:0] aligned;
    logic [work_w-1:0] sum;
    logic              sticky;

    // bits of the smaller mantissa that fall off the right end
    assign lost_mask = ~({work_w{1'b1}} << s1.exp_diff);
    assign sticky    = |(s1.man_small & lost_mask);

    assign shifted = s1.man_small >> s1.exp_diff;
    assign aligned = shifted | {{(work_w-1){1'b0}}, sticky};  // fold lost bits into sticky

    // big was ordered first, so the difference never goes negative
    always_comb begin
        if (s1.sub) begin
            sum = s1.man_big - aligned;
        end else begin
            sum = s1.man_big + aligned;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2.valid <= 1'b0;
        end else begin
            s2.valid <= s1.valid;
        end
    end

    always_ff @(posedge clk) begin
        s2.sign          <= s1.sign;
        s2.exp_big       <= s1.exp_big;
        s2.man_big       <= sum;            // carries the sum from here on
        s2.both_zero_neg <= s1.both_zero_neg;
    end

endmodule

`default_nettype wire

//--- hw/fp_normalize_round.sv
`default_nettype none

module fp_normalize_round
    import fp_pkg::*;
#(
    parameter int work_w = ext_w
) (
    input  logic     clk,
    input  logic     rst,
    fp_stage_if.dst  s2,
    output logic     out_valid,
    output fp_word_t result
);

    localparam int lz_w = $clog2(work_w);

    logic [lz_w-1:0]   lz;
    exp_t              lz_ext;
    exp_t              e_m1;
    exp_t              shamt;
    logic [work_w-1:0] norm;
    exp_wide_t         exp_n;
    exp_t              exp_field;
    logic              guard;
    logic              round_bit;
    logic              sticky;
    logic              lsb;
    logic              round_up;
    logic [word_w-2:0] mag;
    fp_word_t          packed_word;

    // leading zeros below the carry bit, hidden position counts as 0
    always_comb begin
        lz = lz_w'(work_w - 1);
        for (int i = 0; i < work_w - 1; i++) begin
            if (s2.man_big[i]) begin
                lz = lz_w'(work_w - 2 - i);
            end
        end
    end

    assign lz_ext = exp_t'(lz);
    assign e_m1   = s2.exp_big - exp_t'(1);
    assign shamt  = (lz_ext > e_m1) ? e_m1 : lz_ext;  // stop at subnormal range

    always_comb begin
        if (s2.man_big[work_w-1]) begin
            // carry out, one place right, keep sticky
            norm  = {1'b0, s2.man_big[work_w-1:2], |s2.man_big[1:0]};
            exp_n = exp_wide_t'(s2.exp_big) + exp_wide_t'(1);
        end else begin
            norm  = s2.man_big << shamt;
            exp_n = exp_wide_t'(s2.exp_big) - exp_wide_t'(shamt);
        end
    end

    // no hidden bit left means subnormal, exponent field 0
    assign exp_field = norm[work_w-2] ? exp_n[exp_w-1:0] : '0;

    assign guard     = norm[grs_w-1];
    assign round_bit = norm[grs_w-2];
    assign sticky    = norm[grs_w-3];
    assign lsb       = norm[grs_w];
    assign round_up  = guard & (round_bit | sticky | lsb);  // nearest, ties to even

    // round carry ripples into the exponent, covering renormalize and inf
    assign mag = {exp_field, norm[grs_w +: man_w]} + (word_w-1)'(round_up);

    always_comb begin
        if (s2.man_big == '0) begin
            packed_word = {s2.both_zero_neg, {(word_w-1){1'b0}}};  // exact zero
        end else if (exp_n >= exp_wide_t'(exp_max)) begin
            packed_word = {s2.sign, exp_t'(exp_max), {man_w{1'b0}}};
        end else begin
            packed_word = {s2.sign, mag};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s2.valid;
        end
    end

    always_ff @(posedge clk) begin
        result <= packed_word;
    end

endmodule

`default_nettype wire

//--- hw/fp32_addsub.sv
`default_nettype none

module fp32_addsub
    import fp_pkg::*;
#(
    parameter int work_w = ext_w
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  logic     op_add,     // 1 add, 0 subtract
    input  fp_word_t operand_a,
    input  fp_word_t operand_b,
    output logic     out_valid,
    output fp_word_t result
);

    fp_stage_if #(.work_w(work_w)) s1 ();
    fp_stage_if #(.work_w(work_w)) s2 ();

    // stage 1, order operands and pick the effective operation
    fp_operand_order #(.work_w(work_w)) u_order (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op_add    (op_add),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .s1        (s1.src)
    );

    // stage 2, align and add
    fp_align_add #(.work_w(work_w)) u_align (
        .clk (clk),
        .rst (rst),
        .s1  (s1.dst),
        .s2  (s2.src)
    );

    // stage 3, normalize, round, pack
    fp_normalize_round #(.work_w(work_w)) u_round (
        .clk       (clk),
        .rst       (rst),
        .s2        (s2.dst),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

`default_nettype wire

//--- tests/fp32_addsub_tb.sv
`default_nettype none

module fp32_addsub_tb
    import fp_pkg::*;
;

    localparam int reset_cycles = 5;
    localparam int latency      = 3;
    localparam int margin       = 20;
    localparam int n_random     = 24;

    typedef struct packed {
        fp_word_t a;
        fp_word_t b;
        logic     add;
        fp_word_t want;
    } vec_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    logic     op_add;
    fp_word_t operand_a;
    fp_word_t operand_b;
    logic     out_valid;
    fp_word_t result;

    vec_t     vectors[$];
    fp_word_t exp_q[$];       // expected words in issue order
    int       stamp_q[$];     // cycle at which the DUT took each input
    int       cycle       = 0;
    int       cycle_limit = 0;
    int       pass_count  = 0;
    int       fail_count  = 0;
    int       done_count  = 0;
    int       recv_count  = 0;  // results that came with out_valid on time
    logic [7:0] lfsr_state = 8'd58;

    fp32_addsub u_fp32_addsub (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op_add    (op_add),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .out_valid (out_valid),
        .result    (result)
    );

    always #4 clk = ~clk;

    // x^8 + x^6 + x^5 + x^4 + 1, right-shifting form
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        logic [7:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 8'hb8;
        return n;
    endfunction

    task automatic take_bits(input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | {31'd0, lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic draw_int(output int v);
        int unsigned mag;
        int unsigned sgn;
        take_bits(20, mag);                 // magnitude below 2^20
        take_bits(1, sgn);
        v = (sgn != 0) ? -int'(mag) : int'(mag);
    endtask

    // exact conversion, valid while |v| < 2^24
    function automatic fp_word_t int_to_fp(input int v);
        logic        sgn;
        int unsigned mag;
        int          p;
        sgn = (v < 0);
        mag = sgn ? int'(-v) : int'(v);
        if (mag == 0) return 32'h0000_0000;
        p = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) p = i;
        end
        return {sgn, 8'(127 + p), 23'((mag << (23 - p)) & 32'h007f_ffff)};
    endfunction

    task automatic add_vec(input fp_word_t a, input fp_word_t b, input logic add,
                           input fp_word_t want);
        vectors.push_back('{a: a, b: b, add: add, want: want});
    endtask

    task automatic load_table();
        int ra;
        int rb;
        int unsigned rop;
        add_vec(32'h3fc0_0000, 32'h4010_0000, 1'b1, 32'h4070_0000);  // 1.5 + 2.25
        add_vec(32'h4040_0000, 32'h40a0_0000, 1'b0, 32'hc000_0000);  // 3 - 5
        add_vec(32'hbfc0_0000, 32'hc010_0000, 1'b0, 32'h3f40_0000);  // -1.5 - -2.25
        add_vec(32'hc080_0000, 32'hbf00_0000, 1'b1, 32'hc090_0000);  // -4 + -0.5
        add_vec(32'h3f80_0000, 32'h3380_0000, 1'b1, 32'h3f80_0000);  // tie stays even
        add_vec(32'h3f80_0000, 32'h3440_0000, 1'b1, 32'h3f80_0002);  // tie rounds up
        add_vec(32'h3f80_0001, 32'h3f80_0000, 1'b0, 32'h3400_0000);  // cancellation
        add_vec(32'h0040_0000, 32'h0040_0000, 1'b1, 32'h0080_0000);  // halves to min normal
        add_vec(32'h0080_0001, 32'h0080_0000, 1'b0, 32'h0000_0001);  // down to subnormal
        add_vec(32'h00c0_0000, 32'h0080_0000, 1'b0, 32'h0040_0000);
        add_vec(32'h4049_0fdb, 32'h4049_0fdb, 1'b0, 32'h0000_0000);  // x - x
        add_vec(32'h8000_0000, 32'h8000_0000, 1'b1, 32'h8000_0000);  // -0 + -0
        add_vec(32'h7f7f_ffff, 32'h7f7f_ffff, 1'b1, 32'h7f80_0000);  // overflow
        add_vec(32'hff7f_ffff, 32'h7f7f_ffff, 1'b0, 32'hff80_0000);
        for (int i = 0; i < n_random; i++) begin
            draw_int(ra);
            draw_int(rb);
            take_bits(1, rop);
            add_vec(int_to_fp(ra), int_to_fp(rb), rop[0],
                    int_to_fp((rop[0] != 0) ? ra + rb : ra - rb));
        end
    endtask

    // result check and strobe timing, sampled on the edge
    always @(posedge clk) begin
        logic     due;
        fp_word_t want;
        cycle <= cycle + 1;
        if (cycle >= 1) begin
            due = (stamp_q.size() > 0) && (stamp_q[0] + latency == cycle);
            assert (out_valid === due) else begin
                fail_count++;
                if (due) begin
                    $display("test %0d: no out_valid %0d cycles after its input",
                             done_count, latency);
                end else begin
                    $display("out_valid was high at %0t with no result due", $time);
                end
            end
            if (due) begin
                want = exp_q.pop_front();
                void'(stamp_q.pop_front());
                if (out_valid === 1'b1) begin
                    assert (result === want) begin
                        pass_count++;
                        $display("ok   test %0d result %h", done_count, result);
                    end else begin
                        fail_count++;
                        $display("FAIL t=%0t result got %h expected %h", $time, result, want);
                    end
                    recv_count++;
                end
                done_count++;
            end
        end
        if (in_valid === 1'b1) stamp_q.push_back(cycle);
    end

    always @(posedge clk) begin
        if (cycle_limit != 0 && cycle >= cycle_limit) begin
            $display("timeout: out_valid never came for %0d operations",
                     vectors.size() - recv_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        op_add    = 1'b0;
        operand_a = '0;
        operand_b = '0;
        load_table();
        cycle_limit = reset_cycles + vectors.size() + latency + margin;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        foreach (vectors[i]) begin
            operand_a <= vectors[i].a;  // back to back, one per cycle
            operand_b <= vectors[i].b;
            op_add    <= vectors[i].add;
            in_valid  <= 1'b1;
            exp_q.push_back(vectors[i].want);
            @(posedge clk);
        end
        in_valid <= 1'b0;
        wait (recv_count == vectors.size());
        @(posedge clk);
        $display("passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/fp_pkg.sv
hw/fp_stage_if.sv
hw/fp_operand_order.sv
hw/fp_align_add.sv
hw/fp_normalize_round.sv
hw/fp32_addsub.sv
tests/fp32_addsub_tb.sv

//--- Makefile
TOP = fp32_addsub_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
